//--- hw/ramio_pkg.sv
package ramio_pkg;

  // ------------------------------------------------------------
  // sizes
  localparam int ram_address_bitwidth   = 21;  // 64-bit burst words
  localparam int cache_line_ix_bitwidth = 6;
  localparam int line_offset_bitwidth   = 3;   // 8 bytes per line
  localparam int cache_lines            = 2 ** cache_line_ix_bitwidth;
  localparam int cache_tag_bitwidth     = ram_address_bitwidth - cache_line_ix_bitwidth;
  localparam int writeback_wait_cycles  = 2;   // gap after a burst write

  // uart timing
  localparam int clock_frequency_hz = 30_000_000;
  localparam int uart_baud_rate     = 3_000_000;
  localparam int uart_bit_cycles    = clock_frequency_hz / uart_baud_rate;
  localparam int uart_tick_bitwidth = $clog2(uart_bit_cycles);

  // ------------------------------------------------------------
  // address map
  localparam int          io_select_lsb      = 4;  // bits above are all ones for i/o
  localparam logic [31:0] io_led_address     = 32'hFFFF_FFFC;
  localparam logic [31:0] io_uart_tx_address = 32'hFFFF_FFF8;
  localparam logic [31:0] io_uart_rx_address = 32'hFFFF_FFF4;
  localparam logic [31:0] rx_empty_value     = 32'hFFFF_FFFF;

  // ------------------------------------------------------------
  // encodings
  typedef enum logic [1:0] {
    wt_none = 2'd0,
    wt_byte = 2'd1,
    wt_half = 2'd2,
    wt_word = 2'd3
  } write_type_e;

  // bit 2 marks the unsigned loads
  typedef enum logic [2:0] {
    rt_none   = 3'b000,
    rt_byte   = 3'b001,
    rt_half   = 3'b010,
    rt_word   = 3'b011,
    rt_byte_u = 3'b101,
    rt_half_u = 3'b110
  } read_type_e;

  typedef enum logic [2:0] {
    cs_sweep,
    cs_idle,
    cs_writeback,
    cs_writeback_wait,
    cs_fill,
    cs_fill_wait,
    cs_respond
  } cache_state_e;

  typedef enum logic [1:0] {
    us_idle,
    us_start,
    us_data,
    us_stop
  } uart_state_e;

  // ------------------------------------------------------------
  // request and response bundles
  typedef struct packed {
    logic        enable;
    write_type_e write_type;
    read_type_e  read_type;
    logic [31:0] address;
    logic [31:0] data_in;
  } ramio_req_t;

  typedef struct packed {
    logic [31:0] data_out;
    logic        data_out_ready;
    logic        busy;
  } ramio_rsp_t;

  typedef struct packed {
    logic        enable;
    logic        write;
    write_type_e size;     // never wt_none
    logic [31:0] address;
    logic [31:0] data;
  } unit_req_t;

  typedef struct packed {
    logic [31:0] rdata;    // raw bytes, right aligned
    logic        rvalid;
    logic        busy;
  } unit_rsp_t;

  typedef struct packed {
    logic                            cmd;  // 0 read, 1 write
    logic                            cmd_en;
    logic [ram_address_bitwidth-1:0] addr;
    logic [63:0]                     wr_data;
    logic [7:0]                      data_mask;
  } br_req_t;

  typedef struct packed {
    logic [63:0] rd_data;
    logic        rd_data_valid;
  } br_rsp_t;

endpackage

//--- hw/ramio_dispatch.sv
module ramio_dispatch (
  input  logic                  clk,
  input  logic                  reset,
  input  ramio_pkg::ramio_req_t core_req,
  output ramio_pkg::ramio_rsp_t core_rsp,
  output ramio_pkg::unit_req_t  cache_req,
  input  ramio_pkg::unit_rsp_t  cache_rsp,
  output ramio_pkg::unit_req_t  io_req,
  input  ramio_pkg::unit_rsp_t  io_rsp
);
  import ramio_pkg::*;

  logic       is_io;
  logic       is_write;
  unit_req_t  unit_req;
  logic       accepted_q;      // enable seen last cycle
  logic       pending_io_q;    // owner of the open load
  read_type_e pending_type_q;
  unit_rsp_t  owner_rsp;

  function automatic logic [31:0] extend(input logic [31:0] raw, input read_type_e rt);
    case (rt)
      rt_byte:   return {{24{raw[7]}}, raw[7:0]};
      rt_half:   return {{16{raw[15]}}, raw[15:0]};
      rt_byte_u: return {24'b0, raw[7:0]};
      rt_half_u: return {16'b0, raw[15:0]};
      default:   return raw;
    endcase
  endfunction

  // ------------------------------------------------------------
  // decode and steer
  assign is_io    = &core_req.address[31:io_select_lsb];
  assign is_write = (core_req.write_type != wt_none);

  always_comb begin
    unit_req.enable  = core_req.enable;
    unit_req.write   = is_write;
    unit_req.address = core_req.address;
    unit_req.data    = core_req.data_in;
    if (is_write) begin
      unit_req.size = core_req.write_type;
    end else begin
      case (core_req.read_type)
        rt_byte, rt_byte_u: unit_req.size = wt_byte;
        rt_half, rt_half_u: unit_req.size = wt_half;
        default:            unit_req.size = wt_word;
      endcase
    end

    cache_req        = unit_req;
    cache_req.enable = core_req.enable && !is_io;
    io_req           = unit_req;
    io_req.enable    = core_req.enable && is_io;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      accepted_q     <= 1'b0;
      pending_io_q   <= 1'b0;
      pending_type_q <= rt_none;
    end else begin
      accepted_q <= core_req.enable;
      if (core_req.enable && !is_write) begin
        pending_io_q   <= is_io;
        pending_type_q <= core_req.read_type;
      end
    end
  end

  // ------------------------------------------------------------
  // merge results
  assign owner_rsp = pending_io_q ? io_rsp : cache_rsp;

  assign core_rsp.data_out       = extend(owner_rsp.rdata, pending_type_q);
  assign core_rsp.data_out_ready = owner_rsp.rvalid;
  assign core_rsp.busy           = accepted_q || cache_rsp.busy || io_rsp.busy;

  // core honours busy
  assert property (@(posedge clk) disable iff (reset)
    core_req.enable |-> !core_rsp.busy);

endmodule

//--- hw/cache_unit.sv
module cache_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  ramio_pkg::unit_req_t req,
  output ramio_pkg::unit_rsp_t rsp,
  output ramio_pkg::br_req_t   br_req,
  input  ramio_pkg::br_rsp_t   br_rsp
);
  import ramio_pkg::*;

  typedef logic [cache_line_ix_bitwidth-1:0] line_ix_t;
  typedef logic [cache_tag_bitwidth-1:0]     tag_t;

  cache_state_e     state;
  unit_req_t        req_q;        // request held over a miss
  line_ix_t         sweep_ix;
  logic [1:0]       wait_cnt;
  logic             rvalid_q;
  logic [31:0]      rdata_q;

  logic [cache_lines-1:0] valid_bits;
  logic [cache_lines-1:0] dirty_bits;
  tag_t                   tag_mem [cache_lines];
  logic [63:0]            data_mem [cache_lines];

  line_ix_t    req_ix;
  line_ix_t    q_ix;
  line_ix_t    line_ix;
  tag_t        req_tag;
  tag_t        q_tag;
  tag_t        cur_tag;
  logic [63:0] cur_line;
  logic        hit;
  logic        lookup;
  logic        hit_read;
  logic        hit_write;
  logic        fill_done;
  logic        mem_we;
  logic [63:0] mem_wdata;

  // byte lanes of a store, placed by the address offset
  function automatic logic [63:0] merge_line(input logic [63:0] line, input unit_req_t r);
    logic [7:0]  lanes;
    logic [63:0] wide;
    logic [63:0] merged;
    case (r.size)
      wt_byte: lanes = 8'h01;
      wt_half: lanes = 8'h03;
      default: lanes = 8'h0F;
    endcase
    lanes = lanes << r.address[2:0];
    wide  = 64'(r.data) << {r.address[2:0], 3'b000};
    for (int i = 0; i < 8; i++) begin
      merged[i*8 +: 8] = lanes[i] ? wide[i*8 +: 8] : line[i*8 +: 8];
    end
    return merged;
  endfunction

  function automatic logic [31:0] extract(input logic [63:0] line, input logic [2:0] offset);
    return 32'(line >> {offset, 3'b000});
  endfunction

  // ------------------------------------------------------------
  // lookup
  assign req_ix  = req.address[line_offset_bitwidth +: cache_line_ix_bitwidth];
  assign req_tag = req.address[line_offset_bitwidth + cache_line_ix_bitwidth +: cache_tag_bitwidth];
  assign q_ix    = req_q.address[line_offset_bitwidth +: cache_line_ix_bitwidth];
  assign q_tag   = req_q.address[line_offset_bitwidth + cache_line_ix_bitwidth +: cache_tag_bitwidth];

  assign line_ix  = (state == cs_idle) ? req_ix : q_ix;
  assign cur_line = data_mem[line_ix];
  assign cur_tag  = tag_mem[line_ix];
  assign hit      = valid_bits[line_ix] && (cur_tag == req_tag);

  assign lookup    = (state == cs_idle) && req.enable;
  assign hit_read  = lookup && hit && !req.write;
  assign hit_write = lookup && hit && req.write;
  assign fill_done = (state == cs_fill_wait) && br_rsp.rd_data_valid;

  always_comb begin
    mem_we    = 1'b0;
    mem_wdata = cur_line;
    if (hit_write) begin
      mem_we    = 1'b1;
      mem_wdata = merge_line(cur_line, req);
    end else if (fill_done) begin
      mem_we    = 1'b1;  // store on a miss lands in the fresh line
      mem_wdata = req_q.write ? merge_line(br_rsp.rd_data, req_q) : br_rsp.rd_data;
    end
  end

  // ------------------------------------------------------------
  // storage
  always_ff @(posedge clk) begin
    if (mem_we) data_mem[line_ix] <= mem_wdata;
    if (fill_done) tag_mem[q_ix] <= q_tag;
  end

  always_ff @(posedge clk) begin
    if (state == cs_sweep) begin
      valid_bits[sweep_ix] <= 1'b0;
      dirty_bits[sweep_ix] <= 1'b0;
    end else if (fill_done) begin
      valid_bits[q_ix] <= 1'b1;
      dirty_bits[q_ix] <= req_q.write;
    end else if (hit_write) begin
      dirty_bits[req_ix] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (lookup) req_q <= req;
    if (hit_read) begin
      rdata_q <= extract(cur_line, req.address[2:0]);
    end else if (fill_done) begin
      rdata_q <= extract(br_rsp.rd_data, req_q.address[2:0]);
    end
  end

  // ------------------------------------------------------------
  // control FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= cs_sweep;
      sweep_ix <= '0;
      wait_cnt <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= 1'b0;
      case (state)
        cs_sweep: begin
          sweep_ix <= sweep_ix + 1'b1;
          if (&sweep_ix) state <= cs_idle;
        end
        cs_idle: begin
          if (lookup) begin
            if (hit) begin
              rvalid_q <= !req.write;
              state    <= cs_respond;
            end else if (valid_bits[req_ix] && dirty_bits[req_ix]) begin
              state <= cs_writeback;  // victim goes out first
            end else begin
              state <= cs_fill;
            end
          end
        end
        cs_writeback: begin
          wait_cnt <= 2'(writeback_wait_cycles - 1);
          state    <= cs_writeback_wait;
        end
        cs_writeback_wait: begin
          if (wait_cnt == '0) state <= cs_fill;
          else wait_cnt <= wait_cnt - 1'b1;
        end
        cs_fill: state <= cs_fill_wait;
        cs_fill_wait: begin
          if (br_rsp.rd_data_valid) begin
            rvalid_q <= !req_q.write;
            state    <= cs_respond;
          end
        end
        default: state <= cs_idle;  // respond
      endcase
    end
  end

  assign rsp.rdata  = rdata_q;
  assign rsp.rvalid = rvalid_q;
  assign rsp.busy   = (state != cs_idle);

  // burst port, one-cycle command per state
  assign br_req.cmd       = (state == cs_writeback);
  assign br_req.cmd_en    = (state == cs_writeback) || (state == cs_fill);
  assign br_req.addr      = (state == cs_writeback) ? {cur_tag, q_ix} : {q_tag, q_ix};
  assign br_req.wr_data   = cur_line;
  assign br_req.data_mask = '0;

  // a read burst is answered before the next command
  assert property (@(posedge clk) disable iff (reset)
    (br_req.cmd_en && !br_req.cmd) |=> (!br_req.cmd_en until br_rsp.rd_data_valid));

endmodule

//--- hw/io_unit.sv
module io_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  ramio_pkg::unit_req_t req,
  output ramio_pkg::unit_rsp_t rsp,
  input  logic                 uart_rx,
  output logic                 uart_tx,
  output logic [3:0]           led
);
  import ramio_pkg::*;

  typedef logic [uart_tick_bitwidth-1:0] tick_t;

  logic        ack_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic        led_write;
  logic        tx_write;
  logic        rx_read;

  logic        tx_pending;    // byte waiting for the transmitter
  logic [7:0]  tx_data_q;
  logic [7:0]  tx_frame;
  logic        tx_start;
  uart_state_e tx_state;
  tick_t       tx_tick;
  logic [2:0]  tx_bit_ix;

  logic [1:0]  rx_sync;
  uart_state_e rx_state;
  tick_t       rx_tick;
  logic [2:0]  rx_bit_ix;
  logic [7:0]  rx_shift;
  logic [7:0]  rx_byte;
  logic        rx_full;
  logic        rx_bit_end;
  logic        rx_sample;
  logic        rx_done;

  assign led_write = req.enable && req.write && (req.address == io_led_address);
  assign tx_write  = req.enable && req.write && (req.address == io_uart_tx_address);
  assign rx_read   = req.enable && !req.write && (req.address == io_uart_rx_address);
  assign tx_start  = tx_pending && (tx_state == us_idle);

  // ------------------------------------------------------------
  // register access
  always_ff @(posedge clk) begin
    if (reset) begin
      ack_q      <= 1'b0;
      rvalid_q   <= 1'b0;
      led        <= '0;
      tx_pending <= 1'b0;
      rx_full    <= 1'b0;
    end else begin
      ack_q    <= req.enable;
      rvalid_q <= req.enable && !req.write;
      if (led_write) led <= req.data[3:0];
      if (tx_write) tx_pending <= 1'b1;
      else if (tx_start) tx_pending <= 1'b0;
      if (rx_done) rx_full <= 1'b1;  // a fresh byte wins over a read
      else if (rx_read) rx_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (tx_write) tx_data_q <= req.data[7:0];
    if (tx_start) tx_frame <= tx_data_q;
    if (rx_sample) rx_shift <= {rx_sync[1], rx_shift[7:1]};  // lsb arrives first
    if (rx_done) rx_byte <= rx_shift;
    if (req.enable && !req.write) begin
      case (req.address)
        io_led_address:     rdata_q <= {28'b0, led};
        io_uart_rx_address: rdata_q <= rx_full ? {24'b0, rx_byte} : rx_empty_value;
        default:            rdata_q <= '0;
      endcase
    end
  end

  assign rsp.rdata  = rdata_q;
  assign rsp.rvalid = rvalid_q;
  assign rsp.busy   = ack_q || tx_pending;

  // ------------------------------------------------------------
  // 8N1 transmitter
  always_ff @(posedge clk) begin
    if (reset) begin
      tx_state  <= us_idle;
      tx_tick   <= '0;
      tx_bit_ix <= '0;
      uart_tx   <= 1'b1;
    end else if (tx_state == us_idle) begin
      tx_tick <= '0;
      if (tx_start) begin
        uart_tx  <= 1'b0;  // start bit
        tx_state <= us_start;
      end
    end else if (tx_tick != tick_t'(uart_bit_cycles - 1)) begin
      tx_tick <= tx_tick + 1'b1;
    end else begin
      tx_tick <= '0;
      case (tx_state)
        us_start: begin
          uart_tx   <= tx_frame[0];
          tx_bit_ix <= '0;
          tx_state  <= us_data;
        end
        us_data: begin
          if (&tx_bit_ix) begin
            uart_tx  <= 1'b1;
            tx_state <= us_stop;
          end else begin
            uart_tx   <= tx_frame[tx_bit_ix + 1'b1];
            tx_bit_ix <= tx_bit_ix + 1'b1;
          end
        end
        default: tx_state <= us_idle;  // stop bit done
      endcase
    end
  end

  // ------------------------------------------------------------
  // receiver with mid-bit sampling
  assign rx_bit_end = (rx_tick == tick_t'(uart_bit_cycles - 1));
  assign rx_sample  = (rx_state == us_data) && rx_bit_end;
  assign rx_done    = (rx_state == us_stop) && rx_bit_end && rx_sync[1];

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_sync   <= 2'b11;
      rx_state  <= us_idle;
      rx_tick   <= '0;
      rx_bit_ix <= '0;
    end else begin
      rx_sync <= {rx_sync[0], uart_rx};
      rx_tick <= rx_tick + 1'b1;
      case (rx_state)
        us_idle: begin
          rx_tick <= '0;
          if (!rx_sync[1]) rx_state <= us_start;
        end
        us_start: begin
          if (rx_tick == tick_t'(uart_bit_cycles / 2 - 1)) begin
            rx_tick   <= '0;
            rx_bit_ix <= '0;
            rx_state  <= rx_sync[1] ? us_idle : us_data;  // drop short glitches
          end
        end
        us_data: begin
          if (rx_bit_end) begin
            rx_tick   <= '0;
            rx_bit_ix <= rx_bit_ix + 1'b1;
            if (&rx_bit_ix) rx_state <= us_stop;
          end
        end
        default: begin
          if (rx_bit_end) begin
            rx_tick  <= '0;
            rx_state <= us_idle;
          end
        end
      endcase
    end
  end

  // a new transmit byte is only taken once the queued one has started
  assert property (@(posedge clk) disable iff (reset)
    tx_write |-> !tx_pending);

endmodule

//--- hw/ramio_top.sv
module ramio_top (
  input  logic                  clk,
  input  logic                  reset,
  input  ramio_pkg::ramio_req_t core_req,
  output ramio_pkg::ramio_rsp_t core_rsp,
  output ramio_pkg::br_req_t    br_req,
  input  ramio_pkg::br_rsp_t    br_rsp,
  input  logic                  uart_rx,
  output logic                  uart_tx,
  output logic [3:0]            led
);
  import ramio_pkg::*;

  unit_req_t cache_req;
  unit_rsp_t cache_rsp;
  unit_req_t io_req;
  unit_rsp_t io_rsp;

  // ------------------------------------------------------------
  // request steering and load extension
  ramio_dispatch dispatch (
    .clk      (clk),
    .reset    (reset),
    .core_req (core_req),
    .core_rsp (core_rsp),
    .cache_req(cache_req),
    .cache_rsp(cache_rsp),
    .io_req   (io_req),
    .io_rsp   (io_rsp)
  );

  cache_unit cache (
    .clk   (clk),
    .reset (reset),
    .req   (cache_req),
    .rsp   (cache_rsp),
    .br_req(br_req),  // burst RAM side
    .br_rsp(br_rsp)
  );

  io_unit io (
    .clk    (clk),
    .reset  (reset),
    .req    (io_req),
    .rsp    (io_rsp),
    .uart_rx(uart_rx),
    .uart_tx(uart_tx),
    .led    (led)
  );

endmodule

//--- verification/burst_ram_model.sv
module burst_ram_model (
  input  logic               clk,
  input  ramio_pkg::br_req_t br_req,
  output ramio_pkg::br_rsp_t br_rsp
);
  timeunit 1ns;
  timeprecision 100ps;
  import ramio_pkg::*;

  typedef logic [ram_address_bitwidth-1:0] word_addr_t;

  logic [63:0] mem [word_addr_t];  // sparse, only written words
  word_addr_t  read_addr;
  int unsigned delay;
  logic        read_busy;

  // untouched words still carry their whole address
  function automatic logic [63:0] fill_word(input word_addr_t a);
    return {2{11'h5a3, a}};
  endfunction

  initial begin
    br_rsp    = '0;
    read_busy = 1'b0;
    delay     = 0;
    read_addr = '0;
  end

  // ------------------------------------------------------------
  // one read in flight at a time
  always @(posedge clk) begin
    br_rsp.rd_data_valid <= 1'b0;
    if (br_req.cmd_en && br_req.cmd) begin
      mem[br_req.addr] = br_req.wr_data;  // zero mask keeps all bytes
    end else if (br_req.cmd_en) begin
      read_addr <= br_req.addr;
      delay     <= 3 + ($urandom % 8);   // 3 to 10 cycles
      read_busy <= 1'b1;
    end else if (read_busy) begin
      if (delay > 1) begin
        delay <= delay - 1;
      end else begin
        read_busy            <= 1'b0;
        br_rsp.rd_data_valid <= 1'b1;
        br_rsp.rd_data       <= mem.exists(read_addr) ? mem[read_addr] : fill_word(read_addr);
      end
    end
  end

endmodule

//--- verification/tb_ramio.sv
module tb_ramio;
  timeunit 1ns;
  timeprecision 100ps;
  import ramio_pkg::*;

  localparam int busy_timeout  = 300;  // cycles
  localparam int ready_timeout = 50;
  localparam int poll_limit    = 100;  // loads of the receive register

  typedef enum {op_store, op_load, op_led, op_poll_rx} op_e;

  typedef struct {
    string       name;
    op_e         op;
    write_type_e wt;
    read_type_e  rt;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expected;
  } entry_t;

  logic       clk;
  logic       reset;
  ramio_req_t core_req;
  ramio_rsp_t core_rsp;
  br_req_t    br_req;
  br_rsp_t    br_rsp;
  wire        uart_loop;  // tx fed straight back into rx
  logic [3:0] led;

  entry_t     tests[$];
  logic [7:0] ref_bytes [logic [31:0]];  // expected RAM contents by byte
  int         error_count;
  int         pass_count;
  int         fail_count;

  ramio_top dut (
    .clk     (clk),
    .reset   (reset),
    .core_req(core_req),
    .core_rsp(core_rsp),
    .br_req  (br_req),
    .br_rsp  (br_rsp),
    .uart_rx (uart_loop),
    .uart_tx (uart_loop),
    .led     (led)
  );

  burst_ram_model ram (
    .clk   (clk),
    .br_req(br_req),
    .br_rsp(br_rsp)
  );

  always #2 clk = ~clk;

  // ------------------------------------------------------------
  // table set-up
  function automatic void add_entry(input string name, input op_e op, input write_type_e wt,
                                    input read_type_e rt, input logic [31:0] addr,
                                    input logic [31:0] data, input logic [31:0] expected);
    tests.push_back('{name, op, wt, rt, addr, data, expected});
  endfunction

  function automatic void add_store(input string name, input write_type_e wt,
                                    input logic [31:0] addr, input logic [31:0] data);
    int bytes;
    case (wt)
      wt_byte: bytes = 1;
      wt_half: bytes = 2;
      default: bytes = 4;
    endcase
    for (int i = 0; i < bytes; i++) begin
      ref_bytes[addr + i] = data[i*8 +: 8];
    end
    add_entry(name, op_store, wt, rt_none, addr, data, '0);
  endfunction

  function automatic void add_load(input string name, input read_type_e rt,
                                   input logic [31:0] addr);
    int          bytes;
    logic [31:0] raw;
    logic [31:0] value;
    case (rt)
      rt_byte, rt_byte_u: bytes = 1;
      rt_half, rt_half_u: bytes = 2;
      default:            bytes = 4;
    endcase
    raw = '0;
    for (int i = 0; i < bytes; i++) begin
      raw[i*8 +: 8] = ref_bytes[addr + i];
    end
    value = raw;
    // signed loads copy the top loaded bit upward
    if (rt == rt_byte || rt == rt_half) begin
      for (int b = bytes * 8; b < 32; b++) begin
        value[b] = raw[bytes*8 - 1];
      end
    end
    add_entry(name, op_load, wt_none, rt, addr, '0, value);
  endfunction

  function automatic void build_table();
    logic [31:0] led_data;
    logic [31:0] tx_data;
    add_store("hit word store", wt_word, 32'h0000_0100, $urandom);
    add_load("hit word load", rt_word, 32'h0000_0100);

    add_store("base word store", wt_word, 32'h0000_0180, $urandom);
    add_store("negative byte store", wt_byte, 32'h0000_0181, $urandom | 32'h80);
    add_store("positive half store", wt_half, 32'h0000_0182, $urandom & 32'hFFFF_7FFF);
    add_store("positive byte store", wt_byte, 32'h0000_0184, $urandom & 32'hFFFF_FF7F);
    add_store("negative half store", wt_half, 32'h0000_0186, $urandom | 32'h8000);
    add_load("byte load negative", rt_byte, 32'h0000_0181);
    add_load("byte_u load negative", rt_byte_u, 32'h0000_0181);
    add_load("half load positive", rt_half, 32'h0000_0182);
    add_load("half_u load positive", rt_half_u, 32'h0000_0182);
    add_load("byte load positive", rt_byte, 32'h0000_0184);
    add_load("half load negative", rt_half, 32'h0000_0186);
    add_load("half_u load negative", rt_half_u, 32'h0000_0186);
    add_load("word load merged", rt_word, 32'h0000_0180);

    // same index, other tag
    add_store("evict store a", wt_word, 32'h0000_0040, $urandom);
    add_store("evict store a+512", wt_word, 32'h0000_0240, $urandom);
    add_load("evict load a", rt_word, 32'h0000_0040);
    add_load("evict load a+512", rt_word, 32'h0000_0240);
    add_store("evict store over hit line", wt_word, 32'h0000_0300, $urandom);
    add_load("refill hit line", rt_word, 32'h0000_0100);

    led_data = $urandom;
    add_entry("led store", op_led, wt_word, rt_none, io_led_address, led_data,
              {28'b0, led_data[3:0]});
    add_entry("led load", op_load, wt_none, rt_word, io_led_address, '0,
              {28'b0, led_data[3:0]});
    add_entry("rx load empty", op_load, wt_none, rt_word, io_uart_rx_address, '0,
              rx_empty_value);
    tx_data = $urandom;
    add_entry("uart tx store", op_store, wt_byte, rt_none, io_uart_tx_address, tx_data, '0);
    add_entry("uart rx poll", op_poll_rx, wt_none, rt_word, io_uart_rx_address, '0,
              {24'b0, tx_data[7:0]});
    add_entry("rx load drained", op_load, wt_none, rt_word, io_uart_rx_address, '0,
              rx_empty_value);
  endfunction

  // ------------------------------------------------------------
  // core side
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  task automatic wait_not_busy(output bit ok);
    int n;
    n = 0;
    @(negedge clk);
    while (core_rsp.busy && n < busy_timeout) begin
      @(negedge clk);
      n++;
    end
    ok = !core_rsp.busy;
  endtask

  task automatic core_access(input entry_t e, output logic [31:0] rdata, output bit ok);
    int n;
    rdata = '0;
    wait_not_busy(ok);
    if (ok) begin
      @(posedge clk);
      core_req.enable     <= 1'b1;
      core_req.write_type <= e.wt;
      core_req.read_type  <= e.rt;
      core_req.address    <= e.addr;
      core_req.data_in    <= e.data;
      @(posedge clk);
      core_req.enable <= 1'b0;
      if (e.wt != wt_none) begin
        wait_not_busy(ok);  // store done once busy drops
      end else begin
        n = 0;
        @(negedge clk);
        while (!core_rsp.data_out_ready && n < ready_timeout) begin
          @(negedge clk);
          n++;
        end
        ok    = core_rsp.data_out_ready;
        rdata = core_rsp.data_out;
      end
    end
  endtask

  task automatic run_entry(input entry_t e, output bit ok);
    logic [31:0] rdata;
    int          polls;
    case (e.op)
      op_store: core_access(e, rdata, ok);
      op_load: begin
        core_access(e, rdata, ok);
        if (ok) check_value("data_out", rdata, e.expected);
      end
      op_led: begin
        core_access(e, rdata, ok);
        if (ok) check_value("led", {28'b0, led}, e.expected);
      end
      default: begin
        polls = 0;
        core_access(e, rdata, ok);
        while (ok && rdata === rx_empty_value && polls < poll_limit) begin
          core_access(e, rdata, ok);
          polls++;
        end
        if (ok && rdata === rx_empty_value) begin
          $display("uart byte never arrived after %0d polls of the receive register", polls);
          error_count++;
        end else if (ok) begin
          check_value("data_out", rdata, e.expected);
        end
      end
    endcase
  endtask

  // ------------------------------------------------------------
  // main sequence
  initial begin
    int errors_before;
    bit ok;
    void'($urandom(32'h2c68));
    clk         = 1'b0;
    reset       = 1'b1;
    core_req    = '0;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    build_table();

    repeat (2) @(posedge clk);
    reset <= 1'b0;

    foreach (tests[i]) begin
      errors_before = error_count;
      run_entry(tests[i], ok);
      if (!ok) begin
        $display("timeout at %0t ns: no response from the DUT during %s", $time, tests[i].name);
        error_count++;
      end
      if (error_count == errors_before) begin
        pass_count++;
        $display("test %0d %s: ok", i, tests[i].name);
      end else begin
        fail_count++;
        $display("test %0d %s: failed", i, tests[i].name);
      end
      if (!ok) break;  // bus state unknown after a hang
    end

    $display("%0d of %0d tests run: %0d ok, %0d failed, %0d errors",
             pass_count + fail_count, tests.size(), pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
hw/ramio_pkg.sv
hw/ramio_dispatch.sv
hw/cache_unit.sv
hw/io_unit.sv
hw/ramio_top.sv
verification/burst_ram_model.sv
verification/tb_ramio.sv

//--- Bender.yml
package:
  name: ramio

sources:
  - files:
      - hw/ramio_pkg.sv
      - hw/ramio_dispatch.sv
      - hw/cache_unit.sv
      - hw/io_unit.sv
      - hw/ramio_top.sv
  - target: test
    files:
      - verification/burst_ram_model.sv
      - verification/tb_ramio.sv
